// ==== Bender.yml ====
package:
  name: bus_integrity_checker

sources:
  - files:
      - source/integrity_pkg.sv
      - source/integrity_capture_stage.sv
      - source/achk_compute_stage.sv
      - source/integrity_compare_stage.sv
      - source/bus_integrity_checker.sv
  - target: test
    files:
      - tests/bus_integrity_checker_sva.sv
      - tests/tb_bus_integrity_checker.sv

// ==== list.f ====
source/integrity_pkg.sv
source/integrity_capture_stage.sv
source/achk_compute_stage.sv
source/integrity_compare_stage.sv
source/bus_integrity_checker.sv
tests/bus_integrity_checker_sva.sv
tests/tb_bus_integrity_checker.sv

// ==== source/achk_compute_stage.sv ====
`timescale 1ns/10ps

module achk_compute_stage (
  input  logic                    clk,
  input  logic                    rst_ni,
  input  logic                    req_i,
  input  logic                    reqpar_err_i,
  input  logic                    we_i,
  input  logic                    dbg_i,
  input  integrity_pkg::addr_t    addr_i,
  input  integrity_pkg::data_t    wdata_i,
  input  integrity_pkg::be_t      be_i,
  input  integrity_pkg::prot_t    prot_i,
  input  integrity_pkg::memtype_t memtype_i,
  input  integrity_pkg::achk_t    achk_i,
  output logic                    req_o,
  output logic                    reqpar_err_o,
  output integrity_pkg::achk_t    achk_exp_o,
  output integrity_pkg::achk_t    achk_rcv_o
);
  import integrity_pkg::*;

  // Checksum the sender should have produced for the stage-1 fields
  achk_t achk_exp;

  ////////////////////////////////////////
  // Expected checksum
  ////////////////////////////////////////

  always_comb begin
    achk_exp = achk_t'(0);

    // Byte lanes of address and write data each get an even parity bit
    for (int unsigned lane = 0; lane < NumLanes; lane++) begin
      achk_exp[AchkAddrLsb + lane] =
        ^addr_i[lane * (AddrWidth / NumLanes) +: (AddrWidth / NumLanes)];
      achk_exp[AchkWdataLsb + lane] =
        ^wdata_i[lane * (DataWidth / NumLanes) +: (DataWidth / NumLanes)];
    end

    // Control bits use odd parity, so an all-zero field still gives a one
    achk_exp[AchkProtBit] = ~^{prot_i, memtype_i};
    achk_exp[AchkBeBit]   = ~^{be_i, we_i};
    achk_exp[AchkDbgBit]  = ~dbg_i;
    // Reserved position is expected to be zero
    achk_exp[AchkRsvdBit] = 1'b0;
  end

  ////////////////////////////////////////
  // Stage register
  ////////////////////////////////////////

  // Expected and received checksums move on with the flags that qualify them
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      req_o        <= 1'b0;
      reqpar_err_o <= 1'b0;
      achk_exp_o   <= achk_t'(0);
      achk_rcv_o   <= achk_t'(0);
    end else begin
      req_o        <= req_i;
      reqpar_err_o <= reqpar_err_i;
      achk_exp_o   <= achk_exp;
      achk_rcv_o   <= achk_i;
    end
  end

endmodule

// ==== source/bus_integrity_checker.sv ====
`timescale 1ns/10ps

module bus_integrity_checker (
  input  logic                      clk,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  logic                      req_i,
  input  logic                      reqpar_i,
  input  logic                      we_i,
  input  logic                      dbg_i,
  input  integrity_pkg::addr_t      addr_i,
  input  integrity_pkg::data_t      wdata_i,
  input  integrity_pkg::be_t        be_i,
  input  integrity_pkg::prot_t      prot_i,
  input  integrity_pkg::memtype_t   memtype_i,
  input  integrity_pkg::achk_t      achk_i,
  output logic                      rsp_valid_o,
  output logic                      integrity_err_o,
  output logic                      alert_o,
  output integrity_pkg::err_mask_t  err_mask_o,
  output integrity_pkg::err_count_t err_count_o
);
  import integrity_pkg::*;

  // Stage 1 to stage 2
  logic     s1_req, s1_reqpar_err, s1_we, s1_dbg;
  addr_t    s1_addr;
  data_t    s1_wdata;
  be_t      s1_be;
  prot_t    s1_prot;
  memtype_t s1_memtype;
  achk_t    s1_achk;

  // Stage 2 to stage 3
  logic  s2_req, s2_reqpar_err;
  achk_t s2_achk_exp, s2_achk_rcv;

  // Capture the raw bus and judge request parity
  integrity_capture_stage u_capture (
    .clk, .rst_ni,
    .req_i, .reqpar_i, .we_i, .dbg_i,
    .addr_i, .wdata_i, .be_i, .prot_i, .memtype_i, .achk_i,
    .req_o(s1_req), .reqpar_err_o(s1_reqpar_err), .we_o(s1_we), .dbg_o(s1_dbg),
    .addr_o(s1_addr), .wdata_o(s1_wdata), .be_o(s1_be), .prot_o(s1_prot),
    .memtype_o(s1_memtype), .achk_o(s1_achk)
  );

  // Rebuild the checksum the sender owed us
  achk_compute_stage u_compute (
    .clk, .rst_ni,
    .req_i(s1_req), .reqpar_err_i(s1_reqpar_err), .we_i(s1_we), .dbg_i(s1_dbg),
    .addr_i(s1_addr), .wdata_i(s1_wdata), .be_i(s1_be), .prot_i(s1_prot),
    .memtype_i(s1_memtype), .achk_i(s1_achk),
    .req_o(s2_req), .reqpar_err_o(s2_reqpar_err),
    .achk_exp_o(s2_achk_exp), .achk_rcv_o(s2_achk_rcv)
  );

  // Classify mismatches and keep the alert and counter
  integrity_compare_stage u_compare (
    .clk, .rst_ni, .clear_i,
    .req_i(s2_req), .reqpar_err_i(s2_reqpar_err),
    .achk_exp_i(s2_achk_exp), .achk_rcv_i(s2_achk_rcv),
    .rsp_valid_o, .integrity_err_o, .alert_o, .err_mask_o, .err_count_o
  );

endmodule

// ==== source/integrity_capture_stage.sv ====
`timescale 1ns/10ps

module integrity_capture_stage (
  input  logic                    clk,
  input  logic                    rst_ni,
  input  logic                    req_i,
  input  logic                    reqpar_i,
  input  logic                    we_i,
  input  logic                    dbg_i,
  input  integrity_pkg::addr_t    addr_i,
  input  integrity_pkg::data_t    wdata_i,
  input  integrity_pkg::be_t      be_i,
  input  integrity_pkg::prot_t    prot_i,
  input  integrity_pkg::memtype_t memtype_i,
  input  integrity_pkg::achk_t    achk_i,
  output logic                    req_o,
  output logic                    reqpar_err_o,
  output logic                    we_o,
  output logic                    dbg_o,
  output integrity_pkg::addr_t    addr_o,
  output integrity_pkg::data_t    wdata_o,
  output integrity_pkg::be_t      be_o,
  output integrity_pkg::prot_t    prot_o,
  output integrity_pkg::memtype_t memtype_o,
  output integrity_pkg::achk_t    achk_o
);
  import integrity_pkg::*;

  // Sender must drive reqpar as the inverse of req, so equal values are a fault
  logic reqpar_err;

  assign reqpar_err = (reqpar_i == req_i);

  // The bus is sampled on every edge, idle cycles included, because
  // request parity has to hold even when nothing is being requested
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      req_o        <= 1'b0;
      reqpar_err_o <= 1'b0;
      we_o         <= 1'b0;
      dbg_o        <= 1'b0;
      addr_o       <= addr_t'(0);
      wdata_o      <= data_t'(0);
      be_o         <= be_t'(0);
      prot_o       <= prot_t'(0);
      memtype_o    <= memtype_t'(0);
      achk_o       <= achk_t'(0);
    end else begin
      req_o        <= req_i;
      reqpar_err_o <= reqpar_err;
      we_o         <= we_i;
      dbg_o        <= dbg_i;
      addr_o       <= addr_i;
      wdata_o      <= wdata_i;
      be_o         <= be_i;
      prot_o       <= prot_i;
      memtype_o    <= memtype_i;
      // Received checksum travels alongside the fields it covers
      achk_o       <= achk_i;
    end
  end

endmodule

// ==== source/integrity_compare_stage.sv ====
`timescale 1ns/10ps

module integrity_compare_stage (
  input  logic                      clk,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  logic                      req_i,
  input  logic                      reqpar_err_i,
  input  integrity_pkg::achk_t      achk_exp_i,
  input  integrity_pkg::achk_t      achk_rcv_i,
  output logic                      rsp_valid_o,
  output logic                      integrity_err_o,
  output logic                      alert_o,
  output integrity_pkg::err_mask_t  err_mask_o,
  output integrity_pkg::err_count_t err_count_o
);
  import integrity_pkg::*;

  // Bits set here are checksum positions that disagree
  achk_t     achk_diff;
  err_mask_t err_mask_d;
  logic      err_d;
  logic      count_full;

  ////////////////////////////////////////
  // Per-group comparison
  ////////////////////////////////////////

  assign achk_diff = achk_exp_i ^ achk_rcv_i;

  // Checksum groups only count on a request, while parity counts always
  always_comb begin
    err_mask_d            = err_mask_t'(0);
    err_mask_d[ErrAddr]   = req_i & (|achk_diff[AchkAddrLsb +: NumLanes]);
    err_mask_d[ErrCtrl]   = req_i & (|achk_diff[AchkRsvdBit:AchkProtBit]);
    err_mask_d[ErrWdata]  = req_i & (|achk_diff[AchkWdataLsb +: NumLanes]);
    err_mask_d[ErrReqpar] = reqpar_err_i;
  end

  assign err_d = |err_mask_d;

  // Counter holds once every bit is set
  assign count_full = (err_count_o == {ErrCountWidth{1'b1}});

  ////////////////////////////////////////
  // Result and status registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_o     <= 1'b0;
      integrity_err_o <= 1'b0;
      err_mask_o      <= err_mask_t'(0);
    end else begin
      rsp_valid_o     <= req_i;
      integrity_err_o <= err_d;
      err_mask_o      <= err_mask_d;
    end
  end

  // Sticky alert and error count update on the same edge as the strobe.
  // A new error beats a clear arriving in the same cycle
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_o     <= 1'b0;
      err_count_o <= err_count_t'(0);
    end else if (err_d) begin
      alert_o <= 1'b1;
      if (!count_full) begin
        err_count_o <= err_count_o + err_count_t'(1);
      end
    end else if (clear_i) begin
      alert_o     <= 1'b0;
      err_count_o <= err_count_t'(0);
    end
  end

endmodule

// ==== source/integrity_pkg.sv ====
package integrity_pkg;

  ////////////////////////////////////////
  // Bus geometry
  ////////////////////////////////////////

  // Address and write data of the data bus request
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  // Both address and write data are split into this many byte lanes
  localparam int unsigned NumLanes = 4;

  // Width of the address/control checksum carried with each request
  localparam int unsigned AchkWidth = 12;
  // Error counter saturates at the all-ones value of this width
  localparam int unsigned ErrCountWidth = 8;

  ////////////////////////////////////////
  // Checksum bit layout
  ////////////////////////////////////////

  // One parity bit per address byte, starting here
  localparam int unsigned AchkAddrLsb = 0;
  // Inverted parity over prot and memtype
  localparam int unsigned AchkProtBit = 4;
  // Inverted parity over be and we
  localparam int unsigned AchkBeBit = 5;
  // Inverted dbg
  localparam int unsigned AchkDbgBit = 6;
  // Always zero on the wire
  localparam int unsigned AchkRsvdBit = 7;
  // One parity bit per write-data byte, starting here
  localparam int unsigned AchkWdataLsb = 8;

  // Positions inside the per-group error mask
  localparam int unsigned ErrAddr = 0;
  localparam int unsigned ErrCtrl = 1;
  localparam int unsigned ErrWdata = 2;
  localparam int unsigned ErrReqpar = 3;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [NumLanes-1:0] be_t;
  typedef logic [2:0] prot_t;
  typedef logic [1:0] memtype_t;
  typedef logic [AchkWidth-1:0] achk_t;
  // Request parity is the highest group, so it sets the mask width
  typedef logic [ErrReqpar:0] err_mask_t;
  typedef logic [ErrCountWidth-1:0] err_count_t;

endpackage

// ==== tests/bus_integrity_checker_sva.sv ====
`timescale 1ns/10ps

module bus_integrity_checker_sva (
  input logic                      clk,
  input logic                      rst_ni,
  input logic                      clear_i,
  input logic                      rsp_valid_o,
  input logic                      integrity_err_o,
  input logic                      alert_o,
  input integrity_pkg::err_mask_t  err_mask_o,
  input integrity_pkg::err_count_t err_count_o
);
  import integrity_pkg::*;

  // Number of assertion failures seen so far
  int unsigned assert_fails = 0;

  // The strobe is exactly the OR of the mask
  a_err_is_mask: assert property (@(posedge clk) disable iff (!rst_ni)
    integrity_err_o == (err_mask_o != '0))
    else begin
      $error("integrity_err_o disagrees with err_mask_o");
      assert_fails++;
    end

  // Checksum groups are only judged on a request
  a_groups_need_valid: assert property (@(posedge clk) disable iff (!rst_ni)
    (err_mask_o[ErrWdata:ErrAddr] != '0) |-> rsp_valid_o)
    else begin
      $error("checksum group flagged without rsp_valid_o");
      assert_fails++;
    end

  // Only a clear may drop the sticky alert
  a_alert_sticky: assert property (@(posedge clk) disable iff (!rst_ni)
    $fell(alert_o) |-> $past(clear_i))
    else begin
      $error("alert_o fell without clear_i");
      assert_fails++;
    end

  a_count_monotonic: assert property (@(posedge clk) disable iff (!rst_ni)
    (err_count_o < $past(err_count_o)) |-> $past(clear_i))
    else begin
      $error("err_count_o decreased without clear_i");
      assert_fails++;
    end

endmodule

// ==== tests/tb_bus_integrity_checker.sv ====
`timescale 1ns/10ps

module tb_bus_integrity_checker;
  import integrity_pkg::*;

  // A bus cycle driven on one edge shows at the outputs three edges later
  localparam int unsigned Latency = 3;
  localparam int unsigned ResetCycles = 5;
  localparam int unsigned WaitLimit = 20;

  logic       clk, rst_ni, clear_i;
  logic       req_i, reqpar_i, we_i, dbg_i;
  addr_t      addr_i;
  data_t      wdata_i;
  be_t        be_i;
  prot_t      prot_i;
  memtype_t   memtype_i;
  achk_t      achk_i;
  logic       rsp_valid_o, integrity_err_o, alert_o;
  err_mask_t  err_mask_o;
  err_count_t err_count_o;

  logic [31:0] lfsr_state = 32'hb2e76c58;
  int unsigned drive_cnt = 0;
  int unsigned checked_cnt = 0;
  int unsigned value_errs = 0;
  int unsigned other_errs = 0;
  bit          stim_done = 1'b0;

  // Expected results in drive order, each tagged with its drive number
  err_mask_t   exp_mask_q[$];
  logic        exp_req_q[$];
  int unsigned exp_stamp_q[$];

  bus_integrity_checker dut (
    .clk, .rst_ni, .clear_i,
    .req_i, .reqpar_i, .we_i, .dbg_i,
    .addr_i, .wdata_i, .be_i, .prot_i, .memtype_i, .achk_i,
    .rsp_valid_o, .integrity_err_o, .alert_o, .err_mask_o, .err_count_o
  );

  bind bus_integrity_checker bus_integrity_checker_sva u_sva (
    .clk, .rst_ni, .clear_i,
    .rsp_valid_o, .integrity_err_o, .alert_o, .err_mask_o, .err_count_o
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////

  // Taps 32, 22, 2 and 1 give a maximal-length sequence
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_bit()};
    end
    return val;
  endfunction

  // Index of one checksum bit, 0 to 11
  function automatic int random_flip();
    return int'(rand_bits(4) % 12);
  endfunction

  // Corrupts about one request in four
  function automatic int maybe_flip();
    if (rand_bits(2) == 0) begin
      return random_flip();
    end
    return -1;
  endfunction

  // Checksum the sender owes for the given fields
  function automatic achk_t ref_achk(addr_t addr, data_t wdata, be_t be, prot_t prot,
                                     memtype_t memtype, logic we, logic dbg);
    achk_t sum;
    sum = '0;
    for (int i = 0; i < 4; i++) begin
      sum[i]     = ^addr[8*i +: 8];
      sum[8 + i] = ^wdata[8*i +: 8];
    end
    sum[4] = ~(^prot ^ ^memtype);
    sum[5] = ~(^be ^ we);
    sum[6] = ~dbg;
    sum[7] = 1'b0;
    return sum;
  endfunction

  // Groups flagged for what was sent; parity is judged on idle cycles too
  function automatic err_mask_t ref_mask(logic req, logic reqpar, achk_t sent, achk_t good);
    achk_t     diff;
    err_mask_t mask;
    diff = sent ^ good;
    mask = '0;
    if (req) begin
      mask[ErrAddr]  = |diff[3:0];
      mask[ErrCtrl]  = |diff[7:4];
      mask[ErrWdata] = |diff[11:8];
    end
    mask[ErrReqpar] = (reqpar !== ~req);
    return mask;
  endfunction

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // A negative flip leaves the checksum intact
  task automatic drive_cycle(logic req, logic bad_par, int flip, logic clr);
    addr_t    addr;
    data_t    wdata;
    be_t      be;
    prot_t    prot;
    memtype_t memtype;
    logic     we, dbg, reqpar;
    achk_t    good, sent;
    addr    = rand_bits(32);
    wdata   = rand_bits(32);
    be      = be_t'(rand_bits(4));
    prot    = prot_t'(rand_bits(3));
    memtype = memtype_t'(rand_bits(2));
    we      = (rand_bits(1) != 0);
    dbg     = (rand_bits(1) != 0);
    good    = ref_achk(addr, wdata, be, prot, memtype, we, dbg);
    sent    = good;
    if (flip >= 0) begin
      sent[flip] = ~sent[flip];
    end
    reqpar = bad_par ? req : ~req;
    @(posedge clk);
    req_i     <= req;
    reqpar_i  <= reqpar;
    we_i      <= we;
    dbg_i     <= dbg;
    addr_i    <= addr;
    wdata_i   <= wdata;
    be_i      <= be;
    prot_i    <= prot;
    memtype_i <= memtype;
    achk_i    <= sent;
    clear_i   <= clr;
    drive_cnt++;
    exp_mask_q.push_back(ref_mask(req, reqpar, sent, good));
    exp_req_q.push_back(req);
    exp_stamp_q.push_back(drive_cnt);
  endtask

  task automatic report_mismatch(string what, int got, int exp);
    $display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    value_errs++;
  endtask

  initial begin : stimulus_proc
    int unsigned target;
    int unsigned drain_cnt;
    rst_ni    = 1'b0;
    clear_i   = 1'b0;
    req_i     = 1'b0;
    reqpar_i  = 1'b1;
    we_i      = 1'b0;
    dbg_i     = 1'b0;
    addr_i    = '0;
    wdata_i   = '0;
    be_i      = '0;
    prot_i    = '0;
    memtype_i = '0;
    achk_i    = '0;
    repeat (ResetCycles) @(posedge clk);
    rst_ni <= 1'b1;

    // Clean traffic with requests and idle cycles mixed at random
    for (int i = 0; i < 40; i++) drive_cycle(rand_bits(1) != 0, 1'b0, -1, 1'b0);
    // One corrupted checksum bit per request
    for (int i = 0; i < 24; i++) drive_cycle(1'b1, 1'b0, random_flip(), 1'b0);
    // Wrong parity alone on idle cycles, then on requests alternately with a checksum fault
    for (int i = 0; i < 6; i++) drive_cycle(1'b0, 1'b1, -1, 1'b0);
    for (int i = 0; i < 6; i++) begin
      drive_cycle(1'b1, 1'b1, (i % 2 == 0) ? random_flip() : -1, 1'b0);
    end

    // Alert has to survive clean traffic until cleared
    repeat (8) drive_cycle(1'b1, 1'b0, -1, 1'b0);
    drive_cycle(1'b0, 1'b0, -1, 1'b1);
    repeat (4) drive_cycle(1'b1, 1'b0, -1, 1'b0);
    // Clear two cycles after a fault reaches the compare stage with it
    drive_cycle(1'b1, 1'b0, 2, 1'b0);
    drive_cycle(1'b1, 1'b0, -1, 1'b0);
    drive_cycle(1'b1, 1'b0, -1, 1'b1);
    repeat (4) drive_cycle(1'b1, 1'b0, -1, 1'b0);
    drive_cycle(1'b0, 1'b0, -1, 1'b1);

    // Enough faults to hit the counter ceiling
    for (int i = 0; i < 270; i++) drive_cycle(1'b1, 1'b0, random_flip(), 1'b0);
    repeat (4) drive_cycle(1'b1, 1'b0, -1, 1'b0);
    drive_cycle(1'b0, 1'b0, -1, 1'b1);

    // Back-to-back requests with occasional faults
    for (int i = 0; i < 32; i++) drive_cycle(1'b1, 1'b0, maybe_flip(), 1'b0);

    // Idle cycles until every result has been compared
    target    = drive_cnt;
    drain_cnt = 0;
    while (checked_cnt < target && drain_cnt < WaitLimit) begin
      drive_cycle(1'b0, 1'b0, -1, 1'b0);
      drain_cnt++;
    end
    if (checked_cnt < target) begin
      $display("Timeout: %0d results never reached the outputs", target - checked_cnt);
      other_errs++;
    end
    stim_done = 1'b1;

    $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
             value_errs, other_errs, dut.u_sva.assert_fails);
    if (value_errs == 0 && other_errs == 0 && dut.u_sva.assert_fails == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  ////////////////////////////////////////
  // Comparison on the falling edge
  ////////////////////////////////////////

  initial begin : compare_proc
    err_mask_t   exp_mask;
    logic        exp_req;
    logic        prev_clear;
    logic        model_alert;
    err_count_t  model_count;
    int unsigned wait_cnt;
    prev_clear  = 1'b0;
    model_alert = 1'b0;
    model_count = '0;
    wait_cnt    = 0;
    while (rst_ni !== 1'b1 && wait_cnt < WaitLimit) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (rst_ni !== 1'b1) begin
      $display("Timeout: reset was never released");
      other_errs++;
    end
    forever begin
      @(negedge clk);
      if (!stim_done && drive_cnt > Latency) begin
        if (exp_stamp_q.size() == 0 || exp_stamp_q[0] != drive_cnt - Latency) begin
          $display("No expected result queued for drive %0d", drive_cnt - Latency);
          other_errs++;
        end else begin
          void'(exp_stamp_q.pop_front());
          exp_mask = exp_mask_q.pop_front();
          exp_req  = exp_req_q.pop_front();
          // Clear was sampled on the edge that produced this result
          if (exp_mask != '0) begin
            model_alert = 1'b1;
            if (model_count != '1) model_count++;
          end else if (prev_clear) begin
            model_alert = 1'b0;
            model_count = '0;
          end
          if (rsp_valid_o !== exp_req) report_mismatch("rsp_valid_o", rsp_valid_o, exp_req);
          if (err_mask_o !== exp_mask) report_mismatch("err_mask_o", err_mask_o, exp_mask);
          if (integrity_err_o !== (exp_mask != '0)) begin
            report_mismatch("integrity_err_o", integrity_err_o, exp_mask != '0);
          end
          if (alert_o !== model_alert) report_mismatch("alert_o", alert_o, model_alert);
          if (err_count_o !== model_count) begin
            report_mismatch("err_count_o", err_count_o, model_count);
          end
          checked_cnt++;
        end
      end
      prev_clear = clear_i;
    end
  end

endmodule
